//--- Bender.yml
package:
  name: conv_pool

sources:
  - files:
      - verilog/conv_geom_pkg.sv
      - verilog/conv_arith_pkg.sv
      - verilog/fmap_buffer.sv
      - verilog/window_scan.sv
      - verilog/conv_mac.sv
      - verilog/max_pool.sv
      - verilog/conv_pool_top.sv
  - target: simulation
    files:
      - sim/conv_pool_assert.sv
      - sim/conv_pool_checker.sv
      - sim/tb_conv_pool.sv

//--- conv_pool.f
verilog/conv_geom_pkg.sv
verilog/conv_arith_pkg.sv
verilog/fmap_buffer.sv
verilog/window_scan.sv
verilog/conv_mac.sv
verilog/max_pool.sv
verilog/conv_pool_top.sv
sim/conv_pool_assert.sv
sim/conv_pool_checker.sv
sim/tb_conv_pool.sv

//--- sim/conv_pool_assert.sv
module conv_pool_assert (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_start,
    input  logic i_busy,
    input  logic i_out_valid,
    input  logic i_done
);

    logic started;    // a start has been seen since reset
    int   fail_cnt = 0;

    always_ff @(posedge clk) begin
        if (!i_rst_n)
            started <= 1'b0;
        else if (i_start)
            started <= 1'b1;
    end

    a_valid_in_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_out_valid |-> i_busy)
        else begin
            fail_cnt++;
            $error("o_out_valid high while o_busy is low");
        end

    // done marks the last output, the scan goes idle right after
    a_done_with_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_done |-> i_out_valid ##1 !i_busy)
        else begin
            fail_cnt++;
            $error("o_done without o_out_valid, or o_busy still high after it");
        end

    a_quiet_until_start: assert property (@(posedge clk) disable iff (!i_rst_n)
        !started |-> !i_out_valid && !i_done)
        else begin
            fail_cnt++;
            $error("output seen after reset before any start");
        end

endmodule

bind conv_pool_top conv_pool_assert i_conv_pool_assert (
    .clk(clk), .i_rst_n(i_rst_n), .i_start(i_start),
    .i_busy(o_busy), .i_out_valid(o_out_valid), .i_done(o_done)
);

//--- sim/conv_pool_checker.sv
module conv_pool_checker import conv_geom_pkg::*, conv_arith_pkg::*; #(
    parameter int IMG_W = 8,
    parameter int IMG_H = 8
) (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  logic                          i_start,
    input  logic                          i_busy,
    input  logic                          i_out_valid,
    input  pixel_t                        i_out_data,
    input  coord_t                        i_out_row,
    input  coord_t                        i_out_col,
    input  logic                          i_done,
    input  pixel_t [IMG_W*IMG_H/4-1:0]    i_exp,
    output int                            o_runs,
    output int                            o_checks,
    output int                            o_errors
);

    localparam int n_pool = IMG_W * IMG_H / 4;
    localparam int pool_w = IMG_W / 2;

    int   idx;           // next expected pooled output
    int   done_cnt;
    logic run_active;
    logic seen_start;
    logic busy_q;

    initial begin
        o_runs     = 0;
        o_checks   = 0;
        o_errors   = 0;
        idx        = 0;
        done_cnt   = 0;
        run_active = 1'b0;
        seen_start = 1'b0;
        busy_q     = 1'b0;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        o_checks = o_checks + 1;
        if (got !== exp) begin
            o_errors = o_errors + 1;
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h at output %0d (time %0t)",
                     name, got, exp, idx, $time);
        end
    endtask

    task automatic report_problem(input string what);
        o_errors = o_errors + 1;
        $display("ERROR %s (time %0t)", what, $time);
    endtask

    ////////////////////
    // output monitor
    ////////////////////

    // sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (i_rst_n) begin
            if (!seen_start) begin
                o_checks = o_checks + 1;
                if (i_busy || i_out_valid || i_done)
                    report_problem("DUT became active before the first start");
            end
            if (i_out_valid) begin
                if (!run_active || idx >= n_pool) begin
                    report_problem("pooled output outside a run or beyond the last group");
                end else begin
                    compare_value("o_out_data", i_out_data, i_exp[idx]);
                    compare_value("o_out_row", i_out_row, idx / pool_w);    // raster order
                    compare_value("o_out_col", i_out_col, idx % pool_w);
                    compare_value("o_done", i_done, idx == n_pool - 1);
                end
                idx++;
            end else if (i_done) begin
                report_problem("o_done pulsed without a pooled output");
            end
            if (i_done)
                done_cnt++;
            // end of run when busy falls
            if (run_active && busy_q && !i_busy) begin
                compare_value("pooled output count", idx, n_pool);
                compare_value("o_done pulse count", done_cnt, 1);
                run_active = 1'b0;
                o_runs     = o_runs + 1;
            end
            if (i_start && !i_busy) begin
                seen_start = 1'b1;
                run_active = 1'b1;
                idx        = 0;
                done_cnt   = 0;
            end
            busy_q = i_busy;
        end
    end

endmodule

//--- sim/conv_pool_input.txt
// one hex byte per line: weights w0..w8 row-major, bias low byte, bias high byte,
// then 64 pixels at row*8+col, then 16 expected pooled outputs in raster order
01  // weights, top row
02
01
00  // middle row
03
00
ff  // bottom row
fe
ff
ec  // bias -20
ff
00  // pixels, row 0
02
04
06
08
0a
0c
0e
10  // row 1
12
14
16
18
1a
1c
1e
20  // row 2
22
24
26
28
2a
2c
2e
30  // row 3
32
34
36
38
3a
3c
3e
40  // row 4
42
44
46
48
4a
4c
4e
50  // row 5
52
54
56
58
5a
5c
5e
60  // row 6
62
64
66
68
6a
6c
6e
70  // row 7
72
74
76
78
7a
7c
7e
00  // expected, pooled row 0 clips to zero
00
00
00
1c  // pooled row 1
0e
1a
46
7c  // pooled row 2
6e
7a
a6
ff  // pooled row 3 saturates
ff
ff
ff

//--- sim/tb_conv_pool.sv
module tb_conv_pool import conv_geom_pkg::*, conv_arith_pkg::*; #(
    parameter int IMG_W = 8,
    parameter int IMG_H = 8
);

    localparam int n_pix     = IMG_W * IMG_H;
    localparam int n_pool    = n_pix / 4;
    localparam int pix_base  = n_taps + 2;
    localparam int exp_base  = pix_base + n_pix;
    localparam int n_words   = exp_base + n_pool;
    localparam int run_limit = 4 * n_pix + 50;    // cycles allowed per run

    logic                clk;
    logic                rst_n;
    logic                wr_en;
    wr_sel_t             wr_sel;
    logic [11:0]         wr_addr;
    pixel_t              wr_data;
    logic                start;
    logic                busy;
    logic                out_valid;
    pixel_t              out_data;
    coord_t              out_row;
    coord_t              out_col;
    logic                done;
    logic [7:0]          words [n_words];
    pixel_t [n_pool-1:0] exp_pix;
    int                  runs;
    int                  checks;
    int                  errors;
    int                  err_mark;
    logic                timed_out;

    conv_pool_top #(.IMG_W(IMG_W), .IMG_H(IMG_H)) i_conv_pool_top (
        .clk(clk), .i_rst_n(rst_n),
        .i_wr_en(wr_en), .i_wr_sel(wr_sel), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
        .i_start(start), .o_busy(busy), .o_out_valid(out_valid), .o_out_data(out_data),
        .o_out_row(out_row), .o_out_col(out_col), .o_done(done)
    );

    conv_pool_checker #(.IMG_W(IMG_W), .IMG_H(IMG_H)) i_conv_pool_checker (
        .clk(clk), .i_rst_n(rst_n), .i_start(start), .i_busy(busy),
        .i_out_valid(out_valid), .i_out_data(out_data), .i_out_row(out_row),
        .i_out_col(out_col), .i_done(done), .i_exp(exp_pix),
        .o_runs(runs), .o_checks(checks), .o_errors(errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    function automatic int total_errors();
        return errors + i_conv_pool_top.i_conv_pool_assert.fail_cnt;
    endfunction

    task automatic write_word(input wr_sel_t sel, input int addr, input logic [7:0] data);
        wr_en   = 1'b1;
        wr_sel  = sel;
        wr_addr = 12'(addr);
        wr_data = data;
        next_cycle();
    endtask

    task automatic load_image();
        for (int t = 0; t < n_taps; t++)
            write_word(wr_weight, t, words[t]);
        write_word(wr_bias, 0, words[n_taps]);        // low byte
        write_word(wr_bias, 1, words[n_taps + 1]);
        for (int p = 0; p < n_pix; p++)
            write_word(wr_pixel, p, words[pix_base + p]);
        wr_en = 1'b0;
    endtask

    task automatic pulse_start();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
    endtask

    task automatic run_image(input logic stray);
        int prev;
        prev = runs;
        pulse_start();
        if (stray) begin
            for (int i = 0; i < 20 && !busy; i++)
                next_cycle();
            if (!busy) begin
                timed_out = 1'b1;
                $display("timeout: o_busy never rose after start");
            end else begin
                repeat (3) next_cycle();
                pulse_start();    // must be ignored while busy
            end
        end
        for (int i = 0; i < run_limit && runs == prev && !timed_out; i++)
            next_cycle();
        if (runs == prev && !timed_out) begin
            timed_out = 1'b1;
            $display("timeout: run did not finish within %0d cycles", run_limit);
        end
    endtask

    task automatic report_test(input int num, input string name);
        int delta;
        delta    = total_errors() - err_mark;
        err_mark = total_errors();
        $display("test %0d %s: %s, %0d errors", num, name,
                 (delta == 0 && !timed_out) ? "ok" : "bad", delta);
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        rst_n     = 1'b0;
        wr_en     = 1'b0;
        wr_sel    = wr_pixel;
        wr_addr   = '0;
        wr_data   = '0;
        start     = 1'b0;
        timed_out = 1'b0;
        err_mark  = 0;
        $readmemh("sim/conv_pool_input.txt", words);
        for (int k = 0; k < n_pool; k++)
            exp_pix[k] = words[exp_base + k];

        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;

        repeat (10) next_cycle();
        report_test(1, "idle after reset");

        load_image();
        run_image(1'b0);
        report_test(2, "first image run");

        if (!timed_out)
            run_image(1'b1);
        report_test(3, "rerun with start while busy");

        $display("checks %0d, errors %0d, runs %0d", checks, total_errors(), runs);
        if (total_errors() == 0 && !timed_out)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- verilog/conv_arith_pkg.sv
package conv_arith_pkg;

    typedef logic        [7:0]  pixel_t;    // unsigned pixel, clipped result
    typedef logic signed [7:0]  weight_t;
    typedef logic signed [15:0] bias_t;
    typedef logic signed [15:0] prod_t;     // 8u x 8s fits in 16 signed
    typedef logic signed [19:0] acc_t;      // nine products plus bias

    // load target select
    typedef logic [1:0] wr_sel_t;

    localparam wr_sel_t wr_pixel  = 2'd0;
    localparam wr_sel_t wr_weight = 2'd1;
    localparam wr_sel_t wr_bias   = 2'd2;

    localparam int pix_max = 255;    // clip limit

endpackage

//--- verilog/conv_geom_pkg.sv
package conv_geom_pkg;

    ////////////////////
    // window geometry
    ////////////////////

    localparam int n_taps = 9;    // 3x3 window

    // row or column index, also used for pooled coordinates
    typedef logic [7:0] coord_t;

    // one bit per tap, msb is the top-left tap, row-major
    typedef logic [n_taps-1:0] tap_mask_t;

    ////////////////////
    // scan control
    ////////////////////

    typedef enum logic [1:0] {
        st_idle,
        st_scan,     // one window per cycle
        st_drain     // pipeline emptying after last window
    } scan_state_t;

endpackage

//--- verilog/conv_mac.sv
module conv_mac import conv_geom_pkg::*, conv_arith_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_valid,
    input  logic                  i_last,
    input  tap_mask_t             i_mask,
    input  pixel_t [n_taps-1:0]   i_tap_pix,
    input  weight_t [n_taps-1:0]  i_weights,
    input  bias_t                 i_bias,
    output logic                  o_valid,
    output logic                  o_last,
    output pixel_t                o_result
);

    prod_t prod_q [n_taps];
    logic  valid_q;
    logic  last_q;
    acc_t  sum;

    ////////////////////
    // stage 1 multiply
    ////////////////////

    always_ff @(posedge clk) begin
        for (int t = 0; t < n_taps; t++) begin
            if (i_mask[n_taps-1-t])
                prod_q[t] <= $signed({1'b0, i_tap_pix[t]}) * i_weights[t];
            else
                prod_q[t] <= '0;    // zero padding
        end
    end

    ////////////////////
    // stage 2 sum, clip
    ////////////////////

    always_comb begin
        sum = i_bias;
        for (int t = 0; t < n_taps; t++) begin
            sum = sum + prod_q[t];
        end
    end

    always_ff @(posedge clk) begin
        if (sum < 0)
            o_result <= '0;
        else if (sum > pix_max)
            o_result <= pixel_t'(pix_max);
        else
            o_result <= sum[7:0];
    end

    // valid and last follow the data
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
            o_valid <= 1'b0;
            o_last  <= 1'b0;
        end else begin
            valid_q <= i_valid;
            last_q  <= i_valid && i_last;
            o_valid <= valid_q;
            o_last  <= last_q;
        end
    end

endmodule

//--- verilog/conv_pool_top.sv
module conv_pool_top import conv_geom_pkg::*, conv_arith_pkg::*; #(
    parameter int IMG_W = 8,
    parameter int IMG_H = 8
) (
    input  logic          clk,
    input  logic          i_rst_n,
    input  logic          i_wr_en,
    input  wr_sel_t       i_wr_sel,
    input  logic [11:0]   i_wr_addr,
    input  pixel_t        i_wr_data,
    input  logic          i_start,
    output logic          o_busy,
    output logic          o_out_valid,
    output pixel_t        o_out_data,
    output coord_t        o_out_row,
    output coord_t        o_out_col,
    output logic          o_done
);

    coord_t [n_taps-1:0]  tap_row;
    coord_t [n_taps-1:0]  tap_col;
    tap_mask_t            tap_mask;
    logic                 win_valid;
    logic                 quad_last;
    coord_t               pool_row;
    coord_t               pool_col;
    coord_t               pool_row_d1;
    coord_t               pool_row_d2;
    coord_t               pool_col_d1;
    coord_t               pool_col_d2;
    pixel_t [n_taps-1:0]  tap_pix;
    weight_t [n_taps-1:0] weights;
    bias_t                bias;
    logic                 mac_valid;
    logic                 mac_last;
    pixel_t               mac_result;

    fmap_buffer #(.IMG_W(IMG_W), .IMG_H(IMG_H)) i_fmap_buffer (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_wr_en(i_wr_en), .i_wr_sel(i_wr_sel), .i_wr_addr(i_wr_addr), .i_wr_data(i_wr_data),
        .i_tap_row(tap_row), .i_tap_col(tap_col),
        .o_tap_pix(tap_pix), .o_weights(weights), .o_bias(bias)
    );

    window_scan #(.IMG_W(IMG_W), .IMG_H(IMG_H)) i_window_scan (
        .clk(clk), .i_rst_n(i_rst_n), .i_start(i_start),
        .o_busy(o_busy), .o_win_valid(win_valid), .o_quad_last(quad_last),
        .o_tap_row(tap_row), .o_tap_col(tap_col), .o_tap_mask(tap_mask),
        .o_pool_row(pool_row), .o_pool_col(pool_col)
    );

    conv_mac i_conv_mac (
        .clk(clk), .i_rst_n(i_rst_n), .i_valid(win_valid), .i_last(quad_last),
        .i_mask(tap_mask), .i_tap_pix(tap_pix), .i_weights(weights), .i_bias(bias),
        .o_valid(mac_valid), .o_last(mac_last), .o_result(mac_result)
    );

    // pooled coordinates follow the two mac stages
    always_ff @(posedge clk) begin
        pool_row_d1 <= pool_row;
        pool_col_d1 <= pool_col;
        pool_row_d2 <= pool_row_d1;
        pool_col_d2 <= pool_col_d1;
    end

    max_pool #(.IMG_W(IMG_W), .IMG_H(IMG_H)) i_max_pool (
        .clk(clk), .i_rst_n(i_rst_n), .i_valid(mac_valid), .i_last(mac_last),
        .i_result(mac_result), .i_pool_row(pool_row_d2), .i_pool_col(pool_col_d2),
        .o_out_valid(o_out_valid), .o_out_data(o_out_data),
        .o_out_row(o_out_row), .o_out_col(o_out_col), .o_done(o_done)
    );

endmodule

//--- verilog/fmap_buffer.sv
module fmap_buffer import conv_geom_pkg::*, conv_arith_pkg::*; #(
    parameter int IMG_W = 8,
    parameter int IMG_H = 8
) (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_wr_en,
    input  wr_sel_t                i_wr_sel,
    input  logic [11:0]            i_wr_addr,
    input  pixel_t                 i_wr_data,
    input  coord_t [n_taps-1:0]    i_tap_row,
    input  coord_t [n_taps-1:0]    i_tap_col,
    output pixel_t [n_taps-1:0]    o_tap_pix,
    output weight_t [n_taps-1:0]   o_weights,
    output bias_t                  o_bias
);

    localparam int depth  = IMG_W * IMG_H;
    localparam int addr_w = $clog2(depth);

    pixel_t            mem [depth];
    logic [addr_w-1:0] tap_addr [n_taps];

    ////////////////////
    // write port
    ////////////////////

    always_ff @(posedge clk) begin
        if (i_wr_en && i_wr_sel == wr_pixel) begin
            mem[i_wr_addr[addr_w-1:0]] <= i_wr_data;    // row * IMG_W + col
        end
    end

    // filter registers
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_weights <= '0;
            o_bias    <= '0;
        end else if (i_wr_en) begin
            if (i_wr_sel == wr_weight && i_wr_addr[3:0] < n_taps) begin
                o_weights[i_wr_addr[3:0]] <= $signed(i_wr_data);
            end else if (i_wr_sel == wr_bias) begin
                if (i_wr_addr[0])
                    o_bias[15:8] <= i_wr_data;    // high byte
                else
                    o_bias[7:0] <= i_wr_data;
            end
        end
    end

    ////////////////////
    // nine-tap read
    ////////////////////

    for (genvar t = 0; t < n_taps; t++) begin : g_read
        assign tap_addr[t]  = addr_w'(i_tap_row[t] * IMG_W + i_tap_col[t]);
        assign o_tap_pix[t] = mem[tap_addr[t]];
    end

endmodule

//--- verilog/max_pool.sv
module max_pool import conv_geom_pkg::*, conv_arith_pkg::*; #(
    parameter int IMG_W = 8,
    parameter int IMG_H = 8
) (
    input  logic    clk,
    input  logic    i_rst_n,
    input  logic    i_valid,
    input  logic    i_last,
    input  pixel_t  i_result,
    input  coord_t  i_pool_row,
    input  coord_t  i_pool_col,
    output logic    o_out_valid,
    output pixel_t  o_out_data,
    output coord_t  o_out_row,
    output coord_t  o_out_col,
    output logic    o_done
);

    pixel_t cur_max;    // running max of the group
    pixel_t new_max;

    assign new_max = (i_result > cur_max) ? i_result : cur_max;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            cur_max     <= '0;
            o_out_valid <= 1'b0;
            o_done      <= 1'b0;
        end else begin
            o_out_valid <= i_valid && i_last;
            o_done      <= i_valid && i_last &&
                           i_pool_row == IMG_H / 2 - 1 && i_pool_col == IMG_W / 2 - 1;
            if (i_valid)
                cur_max <= i_last ? '0 : new_max;    // clear for next group
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid && i_last) begin
            o_out_data <= new_max;
            o_out_row  <= i_pool_row;
            o_out_col  <= i_pool_col;
        end
    end

endmodule

//--- verilog/window_scan.sv
module window_scan import conv_geom_pkg::*; #(
    parameter int IMG_W = 8,
    parameter int IMG_H = 8
) (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_start,
    output logic                  o_busy,
    output logic                  o_win_valid,
    output logic                  o_quad_last,
    output coord_t [n_taps-1:0]   o_tap_row,
    output coord_t [n_taps-1:0]   o_tap_col,
    output tap_mask_t             o_tap_mask,
    output coord_t                o_pool_row,
    output coord_t                o_pool_col
);

    localparam int last_row = IMG_H / 2 - 1;
    localparam int last_col = IMG_W / 2 - 1;

    scan_state_t state;
    coord_t      grp_row;       // pooled row
    coord_t      grp_col;       // pooled column
    logic [1:0]  pos;           // position inside the 2x2 group
    logic [1:0]  drain_cnt;
    logic        row_off;
    logic        col_off;
    coord_t      ctr_row;
    coord_t      ctr_col;
    logic        grp_end;
    logic        img_end;

    ////////////////////
    // loop nest
    ////////////////////

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state     <= st_idle;
            grp_row   <= '0;
            grp_col   <= '0;
            pos       <= '0;
            drain_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (i_start) begin
                        state   <= st_scan;
                        grp_row <= '0;
                        grp_col <= '0;
                        pos     <= '0;
                    end
                end
                st_scan: begin
                    pos <= pos + 2'd1;    // wraps to 0 after the fourth window
                    if (img_end) begin
                        state     <= st_drain;
                        drain_cnt <= '0;
                    end else if (grp_end) begin
                        if (grp_col == last_col) begin
                            grp_col <= '0;
                            grp_row <= grp_row + 1'b1;
                        end else begin
                            grp_col <= grp_col + 1'b1;
                        end
                    end
                end
                st_drain: begin
                    // last pooled output leaves three cycles after the last window
                    drain_cnt <= drain_cnt + 2'd1;
                    if (drain_cnt == 2'd2)
                        state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign grp_end = (pos == 2'd3);
    assign img_end = grp_end && grp_row == last_row && grp_col == last_col;

    // (0,0) -> down -> down right -> right
    assign row_off = (pos == 2'd1) || (pos == 2'd2);
    assign col_off = pos[1];
    assign ctr_row = {grp_row[6:0], row_off};
    assign ctr_col = {grp_col[6:0], col_off};

    ////////////////////
    // taps and padding
    ////////////////////

    for (genvar t = 0; t < n_taps; t++) begin : g_tap
        logic signed [9:0] nbr_row;
        logic signed [9:0] nbr_col;
        logic              in_img;

        assign nbr_row = $signed({2'b00, ctr_row}) + 10'(t / 3 - 1);
        assign nbr_col = $signed({2'b00, ctr_col}) + 10'(t % 3 - 1);
        assign in_img  = nbr_row >= 0 && nbr_row < IMG_H && nbr_col >= 0 && nbr_col < IMG_W;

        assign o_tap_mask[n_taps-1-t] = in_img;
        assign o_tap_row[t] = in_img ? coord_t'(nbr_row) : '0;    // padded taps read 0
        assign o_tap_col[t] = in_img ? coord_t'(nbr_col) : '0;
    end

    assign o_busy      = (state != st_idle);
    assign o_win_valid = (state == st_scan);
    assign o_quad_last = o_win_valid && grp_end;
    assign o_pool_row  = grp_row;
    assign o_pool_col  = grp_col;

endmodule
